// File: rtl/axi_mem_consts.svh
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// flash region is word addressed behind a byte base
`define FLASH_BASE  32'h3000_0000
`define FLASH_WORDS 1024

// sdram region
`define SDRAM_BASE  32'ha000_0000
`define SDRAM_WORDS 4096

// console transmit window is write only
`define UART_BASE   32'h1000_0000
`define UART_BYTES  8

// response codes on rresp and bresp
`define RESP_OKAY   2'd0
`define RESP_DECERR 2'd3

`endif

// File: rtl/axi_mem_pkg.sv
package axi_mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  len_t;
    typedef logic [1:0]  resp_t;

    // read channel engine
    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_wait_data,
        rd_send
    } read_state_t;

    // write channel engine
    typedef enum logic [2:0] {
        wr_idle,
        wr_have_addr,
        wr_have_data,
        wr_access,
        wr_respond
    } write_state_t;

endpackage

// File: rtl/axi_read_engine.sv
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_read_engine import axi_mem_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  addr_t araddr,
    input  len_t  arlen,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_gnt,
    input  data_t mem_rdata,
    input  logic  mem_err
);

    read_state_t state;
    addr_t       addr_q;
    len_t        len_q;
    len_t        count;

    // beat sequencing
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= rd_idle;
            count <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (arvalid) begin
                        state <= rd_fetch;
                        count <= '0;
                    end
                end
                rd_fetch: begin
                    // hold the request until the arbiter picks us
                    if (rd_gnt) begin
                        state <= rd_wait_data;
                    end
                end
                rd_wait_data: begin
                    state <= rd_send;
                end
                rd_send: begin
                    if (rready) begin
                        if (count == len_q) begin
                            state <= rd_idle;
                        end else begin
                            count <= count + 8'd1;
                            state <= rd_fetch;
                        end
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // burst address steps one word per beat
    always_ff @(posedge clock) begin
        if (state == rd_idle && arvalid) begin
            addr_q <= araddr;
            len_q  <= arlen;
        end else if (state == rd_send && rready && count != len_q) begin
            addr_q <= addr_q + 32'd4;
        end
    end

    // memory output is only valid the cycle after our grant
    always_ff @(posedge clock) begin
        if (state == rd_wait_data) begin
            rdata <= mem_rdata;
            rresp <= mem_err ? `RESP_DECERR : `RESP_OKAY;
        end
    end

    assign arready = (state == rd_idle);
    assign rvalid  = (state == rd_send);
    assign rlast   = rvalid && (count == len_q);
    assign rd_req  = (state == rd_fetch);
    assign rd_addr = addr_q;

endmodule

// File: rtl/axi_write_engine.sv
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_write_engine import axi_mem_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    output logic  wr_req,
    output addr_t wr_addr,
    output data_t wr_data,
    output strb_t wr_strb,
    input  logic  wr_gnt,
    input  logic  mem_err
);

    write_state_t state;
    addr_t        addr_q;
    data_t        data_q;
    strb_t        strb_q;
    logic         sample;

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= wr_idle;
            sample <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            sample <= 1'b0;
            case (state)
                wr_idle: begin
                    // address and data may land together or apart
                    if (awvalid && wvalid) begin
                        state <= wr_access;
                    end else if (awvalid) begin
                        state <= wr_have_addr;
                    end else if (wvalid) begin
                        state <= wr_have_data;
                    end
                end
                wr_have_addr: begin
                    if (wvalid) state <= wr_access;
                end
                wr_have_data: begin
                    if (awvalid) state <= wr_access;
                end
                wr_access: begin
                    if (wr_gnt) begin
                        state  <= wr_respond;
                        sample <= 1'b1;
                    end
                end
                wr_respond: begin
                    if (sample) begin
                        bvalid <= 1'b1;
                    end else if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            data_q <= wdata;
            strb_q <= wstrb;
        end
        // error flag from memory belongs to us only after our grant
        if (sample) begin
            bresp <= mem_err ? `RESP_DECERR : `RESP_OKAY;
        end
    end

    assign awready = (state == wr_idle) || (state == wr_have_data);
    assign wready  = (state == wr_idle) || (state == wr_have_addr);
    assign wr_req  = (state == wr_access);
    assign wr_addr = addr_q;
    assign wr_data = data_q;
    assign wr_strb = strb_q;

endmodule

// File: rtl/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter import axi_mem_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_gnt,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  strb_t wr_strb,
    output logic  wr_gnt,
    output logic  mem_en,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    output strb_t mem_strb
);

    // set when the write engine took the last grant
    logic last_wr;
    logic rd_win;
    logic wr_win;

    // on a tie the side that lost last time goes first
    assign rd_win = rd_req && (!wr_req || last_wr);
    assign wr_win = wr_req && (!rd_req || !last_wr);

    always_ff @(posedge clock) begin
        if (rst) begin
            last_wr <= 1'b1;
        end else if (rd_win) begin
            last_wr <= 1'b0;
        end else if (wr_win) begin
            last_wr <= 1'b1;
        end
    end

    assign rd_gnt = rd_win;
    assign wr_gnt = wr_win;

    // steer the winner onto the single port
    assign mem_en    = rd_win || wr_win;
    assign mem_we    = wr_win;
    assign mem_addr  = wr_win ? wr_addr : rd_addr;
    assign mem_wdata = wr_win ? wr_data : '0;
    assign mem_strb  = wr_win ? wr_strb : '0;

endmodule

// File: rtl/region_memory.sv
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module region_memory import axi_mem_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       mem_en,
    input  logic       mem_we,
    input  addr_t      mem_addr,
    input  data_t      mem_wdata,
    input  strb_t      mem_strb,
    output data_t      mem_rdata,
    output logic       mem_err,
    output logic       uart_valid,
    output logic [7:0] uart_data
);

    localparam int FLASH_AW = $clog2(`FLASH_WORDS);
    localparam int SDRAM_AW = $clog2(`SDRAM_WORDS);

    data_t flash_mem [`FLASH_WORDS];
    data_t sdram_mem [`SDRAM_WORDS];

    addr_t flash_off;
    addr_t sdram_off;
    addr_t uart_off;
    logic  flash_hit;
    logic  sdram_hit;
    logic  uart_hit;

    // offsets below a base wrap high, so one compare covers both ends
    assign flash_off = mem_addr - `FLASH_BASE;
    assign sdram_off = mem_addr - `SDRAM_BASE;
    assign uart_off  = mem_addr - `UART_BASE;
    assign flash_hit = flash_off < 32'(4 * `FLASH_WORDS);
    assign sdram_hit = sdram_off < 32'(4 * `SDRAM_WORDS);
    assign uart_hit  = uart_off < 32'(`UART_BYTES);

    initial begin
        for (int i = 0; i < `FLASH_WORDS; i++) flash_mem[i] = '0;
        for (int i = 0; i < `SDRAM_WORDS; i++) sdram_mem[i] = '0;
    end

    // byte lane writes and registered read port
    always_ff @(posedge clock) begin
        if (mem_en && mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_strb[b] && flash_hit) begin
                    flash_mem[flash_off[FLASH_AW+1:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
                if (mem_strb[b] && sdram_hit) begin
                    sdram_mem[sdram_off[SDRAM_AW+1:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
        if (mem_en && !mem_we) begin
            mem_rdata <= flash_hit ? flash_mem[flash_off[FLASH_AW+1:2]] :
                         sdram_hit ? sdram_mem[sdram_off[SDRAM_AW+1:2]] : '0;
        end
        if (mem_en && mem_we && uart_hit) begin
            uart_data <= mem_wdata[7:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_err    <= 1'b0;
            uart_valid <= 1'b0;
        end else begin
            // console is transmit only
            mem_err    <= mem_en && !(flash_hit || sdram_hit || (uart_hit && mem_we));
            uart_valid <= mem_en && mem_we && uart_hit;
        end
    end

endmodule

// File: rtl/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top import axi_mem_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  addr_t      araddr,
    input  len_t       arlen,
    input  logic       arvalid,
    output logic       arready,
    output data_t      rdata,
    output resp_t      rresp,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,
    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,
    output logic       uart_valid,
    output logic [7:0] uart_data
);

    logic  rd_req;
    logic  rd_gnt;
    addr_t rd_addr;
    logic  wr_req;
    logic  wr_gnt;
    addr_t wr_addr;
    data_t wr_data;
    strb_t wr_strb;
    logic  mem_en;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_strb;
    data_t mem_rdata;
    logic  mem_err;

    axi_read_engine u_read_engine (
        .clock(clock), .rst(rst),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
        .mem_rdata(mem_rdata), .mem_err(mem_err)
    );

    axi_write_engine u_write_engine (
        .clock(clock), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .wr_gnt(wr_gnt), .mem_err(mem_err)
    );

    mem_port_arbiter u_arbiter (
        .clock(clock), .rst(rst),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .wr_gnt(wr_gnt),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_strb(mem_strb)
    );

    region_memory u_memory (
        .clock(clock), .rst(rst),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_strb(mem_strb),
        .mem_rdata(mem_rdata), .mem_err(mem_err),
        .uart_valid(uart_valid), .uart_data(uart_data)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset covers 16 rising edges and drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(negedge clock);
        rst = 1'b0;
    end

endmodule

// File: testbench/axi_mem_tb.sv
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_mem_tb import axi_mem_pkg::*; ();

    localparam int MAX_RECORDS = 64;

    logic       clock;
    logic       rst;
    addr_t      araddr;
    len_t       arlen;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    resp_t      rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    logic       uart_valid;
    logic [7:0] uart_data;

    // five words per record
    logic [31:0] patterns [MAX_RECORDS*5];
    data_t       shadow [addr_t];
    logic [31:0] rand_state;
    int          num_records = 0;
    int          cycle_count = 0;
    int          uart_count = 0;
    logic [7:0]  uart_byte;

    tb_clock_gen clock_gen (.clock(clock), .rst(rst));
    axi_mem_top UUT (.*);

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("ERROR: %s got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // never written words read back as zero
    function automatic data_t shadow_word(input addr_t a);
        return shadow.exists(a) ? shadow[a] : '0;
    endfunction

    function automatic logic is_uart(input addr_t a);
        return a >= `UART_BASE && a < `UART_BASE + `UART_BYTES;
    endfunction

    // mode 1 together, 2 address first, 3 data first
    task automatic send_write(input addr_t addr, input data_t data, input strb_t strb,
                              input logic [2:0] mode, input resp_t want);
        int    a_delay;
        int    w_delay;
        int    uart_before;
        logic  aw_left;
        logic  w_left;
        logic  aw_fire;
        logic  w_fire;
        logic  done;
        logic  stalled;
        resp_t held;
        data_t merged;
        a_delay = (mode == 3'd3) ? 1 + int'(next_random() >> 30) : 0;
        w_delay = (mode == 3'd2) ? 1 + int'(next_random() >> 30) : 0;
        uart_before = uart_count;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        aw_left = 1'b1;
        w_left = 1'b1;
        while (aw_left || w_left) begin
            awvalid = aw_left && a_delay == 0;
            wvalid = w_left && w_delay == 0;
            aw_fire = awvalid && awready;
            w_fire = wvalid && wready;
            @(negedge clock);
            if (aw_fire) aw_left = 1'b0;
            if (w_fire) w_left = 1'b0;
            if (a_delay > 0) a_delay--;
            if (w_delay > 0) w_delay--;
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        // response with random bready stalls
        stalled = 1'b0;
        done = 1'b0;
        while (!done) begin
            bready = 1'b0;
            if (stalled) check_value("bvalid held", 32'(bvalid), 32'd1);
            if (bvalid) begin
                check_value("awready", 32'(awready), 32'd0);
                check_value("wready", 32'(wready), 32'd0);
                if (stalled) check_value("bresp held", 32'(bresp), 32'(held));
                held = bresp;
                stalled = (next_random() >> 30) == 32'd0;
                if (!stalled) begin
                    check_value("bresp", 32'(bresp), 32'(want));
                    bready = 1'b1;
                    done = 1'b1;
                end
            end
            @(negedge clock);
        end
        bready = 1'b0;
        if (is_uart(addr) && want == `RESP_OKAY) begin
            check_value("uart pulses", 32'(uart_count - uart_before), 32'd1);
            check_value("uart_data", 32'(uart_byte), 32'(data[7:0]));
        end else begin
            check_value("uart pulses", 32'(uart_count - uart_before), 32'd0);
        end
        if (want == `RESP_OKAY && !is_uart(addr)) begin
            merged = shadow_word(addr);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
            end
            shadow[addr] = merged;
        end
    endtask

    task automatic run_read(input addr_t addr, input len_t len, input resp_t want);
        data_t expected [256];
        int    beat;
        logic  stalled;
        data_t held_data;
        resp_t held_resp;
        logic  held_last;
        for (int i = 0; i <= int'(len); i++) expected[i] = shadow_word(addr + 32'(4 * i));
        araddr = addr;
        arlen = len;
        arvalid = 1'b1;
        while (!arready) @(negedge clock);
        @(negedge clock);
        arvalid = 1'b0;
        beat = 0;
        stalled = 1'b0;
        while (beat <= int'(len)) begin
            rready = 1'b0;
            if (stalled) check_value("rvalid held", 32'(rvalid), 32'd1);
            if (rvalid) begin
                if (stalled) begin
                    check_value("rdata held", rdata, held_data);
                    check_value("rresp held", 32'(rresp), 32'(held_resp));
                    check_value("rlast held", 32'(rlast), 32'(held_last));
                end
                held_data = rdata;
                held_resp = rresp;
                held_last = rlast;
                stalled = (next_random() >> 30) == 32'd0;
                if (!stalled) begin
                    check_value("rresp", 32'(rresp), 32'(want));
                    if (want == `RESP_OKAY) check_value("rdata", rdata, expected[beat]);
                    check_value("rlast", 32'(rlast), 32'(beat == int'(len)));
                    rready = 1'b1;
                    beat++;
                end
            end
            @(negedge clock);
        end
        rready = 1'b0;
    endtask

    // burst read while writes stream into a separate window
    task automatic run_concurrent(input addr_t raddr, input len_t len, input addr_t wbase,
                                  input resp_t want);
        fork
            run_read(raddr, len, want);
            begin
                for (int i = 0; i <= int'(len); i++) begin
                    send_write(wbase + 32'(4 * i), next_random(), 4'hf, 3'(i % 3 + 1),
                               `RESP_OKAY);
                end
            end
        join
    endtask

    always @(negedge clock) begin
        if (uart_valid) begin
            uart_count <= uart_count + 1;
            uart_byte <= uart_data;
        end
    end

    // watchdog at 300 cycles per record
    initial begin
        wait (num_records > 0);
        while (cycle_count < num_records * 300) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("simulation timed out after %0d cycles", cycle_count);
        abort_run();
    end

    initial begin
        int    base;
        addr_t addr;
        data_t data;
        resp_t want;
        araddr = '0;
        arlen = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        rand_state = 32'h2980;
        foreach (patterns[i]) patterns[i] = '0;
        $readmemh("testbench/axi_mem_patterns.hex", patterns);
        while (num_records < MAX_RECORDS && patterns[5 * num_records] != 32'd0) num_records++;
        if (num_records == 0) begin
            $display("no stimulus records were loaded");
            abort_run();
        end
        @(posedge clock);
        while (rst) @(posedge clock);
        @(negedge clock);
        check_value("{rvalid,bvalid,uart_valid}", {29'd0, rvalid, bvalid, uart_valid}, 32'd0);
        check_value("{arready,awready,wready}", {29'd0, arready, awready, wready}, 32'd7);
        for (int n = 0; n < num_records; n++) begin
            base = 5 * n;
            addr = patterns[base + 1];
            data = patterns[base + 3];
            want = patterns[base + 4][1:0];
            case (patterns[base])
                32'd1, 32'd2, 32'd3: begin
                    send_write(addr, data, patterns[base + 2][3:0], patterns[base][2:0], want);
                end
                32'd4: run_read(addr, patterns[base + 2][7:0], want);
                32'd5: run_concurrent(addr, patterns[base + 2][7:0], data, want);
                default: begin
                    $display("unknown record kind %h in record %0d", patterns[base], n);
                    abort_run();
                end
            endcase
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: axi_mem_sim.f
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/axi_read_engine.sv
rtl/axi_write_engine.sv
rtl/mem_port_arbiter.sv
rtl/region_memory.sv
rtl/axi_mem_top.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f axi_mem_sim.f \
        --top-module axi_mem_tb -o axi_mem_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/axi_mem_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

// File: testbench/axi_mem_patterns.hex
// columns: kind address len_or_strb data expected_resp
// kind 1 both, 2 addr first, 3 data first, 4 read burst, 5 read with writes at data column
1 30000010 f deadbeef 0
4 30000010 0 00000000 0
2 a0000100 f 12345678 0
3 a0000100 5 aabbccdd 0
4 a0000100 0 00000000 0
2 a0000104 f 55667788 0
3 a0000108 c 99aabbcc 0
4 a0000100 3 00000000 0
1 10000000 1 00000041 0
4 10000000 0 00000000 3
1 50000000 f 01020304 3
4 30001000 3 00000000 3
5 a0000100 7 a0000800 0
4 a0000800 7 00000000 0
